// File: rtl/memtest_pkg.sv
/*
  request/response types between the test sequencer and the SDRAM controller.
  one word per request, word addressing only, no byte enables
*/
package memtest_pkg;

  // word address is bank(2) + row(13) + column(10)
  localparam int word_addr_width = 25;
  localparam int data_width      = 32;

  // four passes over the address range, then stop
  typedef enum logic [2:0] {
    phase_write_addr,  // store the address itself
    phase_read_addr,
    phase_write_inv,   // store the complemented address
    phase_read_inv,
    phase_done
  } test_phase_t;

  // single-word request
  // all fields held until ack is seen
  typedef struct packed {
    logic                       stb;
    logic                       we;
    logic [word_addr_width-1:0] addr;
    logic [data_width-1:0]      wdata;
  } mem_req_t;

  // ack is a one-cycle pulse, rdata only meaningful with ack on a read
  typedef struct packed {
    logic                  ack;
    logic [data_width-1:0] rdata;
  } mem_rsp_t;

endpackage

// File: rtl/sdram_pkg.sv
/*
  SDR SDRAM command encoding, timing in clock cycles and the pin bundle.
  timings assume burst length 1, CAS latency 2; every wait here is 2 cycles or more
*/
package sdram_pkg;

  // address layout of the device
  localparam int bank_width = 2;
  localparam int row_width  = 13;  // also the width of the a bus
  localparam int col_width  = 10;
  localparam int dqm_width  = 4;

  // a10 selects auto-precharge / precharge-all
  localparam logic [row_width-1:0] a10_mask = 13'h0400;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    cmd_load_mode = 4'b0000,
    cmd_refresh   = 4'b0001,
    cmd_precharge = 4'b0010,
    cmd_active    = 4'b0011,
    cmd_write     = 4'b0100,
    cmd_read      = 4'b0101,
    cmd_nop       = 4'b0111,
    cmd_deselect  = 4'b1111
  } sdram_cmd_t;

  localparam int t_init_wait      = 200;  // power-up NOPs
  localparam int t_rp             = 2;
  localparam int t_rfc            = 7;
  localparam int t_rcd            = 2;
  localparam int t_mrd            = 2;
  localparam int t_wr_ap          = 4;    // write recovery + auto-precharge
  localparam int cas_latency      = 2;
  localparam int refresh_interval = 780;

  localparam int wait_width    = $clog2(t_init_wait + 1);
  localparam int refresh_width = $clog2(refresh_interval + 1);

  // burst length 1, sequential, CAS latency 2, burst write mode
  localparam logic [row_width-1:0] mode_word = 13'b000_0_00_010_0_000;

  typedef struct packed {
    logic                  cke;
    sdram_cmd_t            cmd;
    logic [bank_width-1:0] ba;
    logic [row_width-1:0]  a;
    logic [dqm_width-1:0]  dqm;
  } sdram_pins_t;

endpackage

// File: rtl/ramtest.sv
/*
  walks 0..test_last_addr four times: write address, read back, write complement,
  read back. one request outstanding at a time; errors are sticky until reset
*/
`timescale 1ns/1ps

module ramtest #(
  parameter int unsigned test_last_addr = 1023
) (
  input  logic                 clk,
  input  logic                 rst,
  input  memtest_pkg::mem_rsp_t rsp,
  output memtest_pkg::mem_req_t req,
  output logic                 test_ended,
  output logic                 test_error
);

  import memtest_pkg::*;

  test_phase_t                phase;
  test_phase_t                next_phase;
  logic [word_addr_width-1:0] addr;
  logic                       stb;
  logic                       we;
  logic                       inv_pass;
  logic                       read_pass;
  logic                       last_addr;
  logic [data_width-1:0]      pattern;

  assign we        = (phase == phase_write_addr) || (phase == phase_write_inv);
  assign read_pass = (phase == phase_read_addr) || (phase == phase_read_inv);
  assign inv_pass  = (phase == phase_write_inv) || (phase == phase_read_inv);
  assign last_addr = (addr == word_addr_width'(test_last_addr));

  // written data and expected read data are the same word
  assign pattern = inv_pass ? ~data_width'(addr) : data_width'(addr);

  always_comb begin
    case (phase)
      phase_write_addr: next_phase = phase_read_addr;
      phase_read_addr:  next_phase = phase_write_inv;
      phase_write_inv:  next_phase = phase_read_inv;
      default:          next_phase = phase_done;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= phase_write_addr;
      addr       <= '0;
      stb        <= 1'b0;
      test_error <= 1'b0;
    end else begin
      // compare in the ack cycle
      if (rsp.ack && read_pass && (rsp.rdata != pattern))
        test_error <= 1'b1;

      if (phase != phase_done) begin
        if (!stb) begin
          stb <= 1'b1;  // first request after reset
        end else if (rsp.ack) begin
          if (last_addr) begin
            addr  <= '0;
            phase <= next_phase;
            if (next_phase == phase_done)
              stb <= 1'b0;
          end else begin
            addr <= addr + 1'b1;  // next request right after ack
          end
        end
      end
    end
  end

  assign test_ended = (phase == phase_done);

  assign req.stb   = stb;
  assign req.we    = we;
  assign req.addr  = addr;
  assign req.wdata = pattern;

  // controller may latch fields late, so nothing moves before ack
  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    (req.stb && !rsp.ack) |=> (req.stb && $stable(req))
  ) else $error("request changed while waiting for ack");

  a_error_sticky: assert property (
    @(posedge clk) disable iff (rst)
    test_error |=> test_error
  ) else $error("test_error fell");

endmodule

// File: rtl/ramctrl.sv
/*
  single-word SDRAM controller, burst length 1, CAS latency 2, auto-precharge always.
  a request is served only when no refresh is owed; dqm is tied low
*/
`timescale 1ns/1ps

module ramctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  memtest_pkg::mem_req_t          req,
  output memtest_pkg::mem_rsp_t          rsp,
  output sdram_pkg::sdram_pins_t         pins,
  inout  wire [memtest_pkg::data_width-1:0] dq
);

  import memtest_pkg::*;
  import sdram_pkg::*;

  typedef enum logic [3:0] {
    st_wait,        // shared countdown, then ret_state
    st_pre_all,
    st_init_ref1,
    st_init_ref2,
    st_load_mode,
    st_idle,
    st_read,
    st_read_wait,
    st_write,
    st_write_ack
  } ctrl_state_t;

  ctrl_state_t             state;
  ctrl_state_t             ret_state;
  logic [wait_width-1:0]   wait_cnt;
  logic                    init_done;

  sdram_cmd_t              cmd_q;
  logic [bank_width-1:0]   ba_q;
  logic [row_width-1:0]    a_q;
  logic                    dq_oe;
  logic [data_width-1:0]   dq_out;
  logic                    ack_q;
  logic [data_width-1:0]   rdata_q;

  logic [refresh_width-1:0] ref_cnt;
  logic                    ref_pending;
  logic                    ref_take;

  logic [bank_width-1:0]   bank;
  logic [row_width-1:0]    row_a;
  logic [row_width-1:0]    col_a;

  // word address split
  assign bank  = req.addr[col_width + row_width +: bank_width];
  assign row_a = req.addr[col_width +: row_width];
  assign col_a = a10_mask | row_width'(req.addr[col_width-1:0]);  // a10 = auto-precharge

  assign ref_take = (state == st_idle) && ref_pending;

  // free-running refresh timer
  always_ff @(posedge clk) begin
    if (rst) begin
      ref_cnt     <= '0;
      ref_pending <= 1'b0;
    end else if (ref_cnt == refresh_width'(refresh_interval - 1)) begin
      ref_cnt     <= '0;
      ref_pending <= 1'b1;
    end else begin
      ref_cnt <= ref_cnt + 1'b1;
      if (ref_take)
        ref_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_wait;  // power-up NOPs first
      ret_state <= st_pre_all;
      wait_cnt  <= wait_width'(t_init_wait - 2);
      cmd_q     <= cmd_nop;
      ba_q      <= '0;
      a_q       <= '0;
      dq_oe     <= 1'b0;
      ack_q     <= 1'b0;
      init_done <= 1'b0;
    end else begin
      cmd_q <= cmd_nop;  // commands last one cycle
      dq_oe <= 1'b0;
      ack_q <= 1'b0;
      case (state)
        st_wait: begin
          if (wait_cnt == '0)
            state <= ret_state;
          else
            wait_cnt <= wait_cnt - 1'b1;
        end
        st_pre_all: begin
          cmd_q     <= cmd_precharge;
          a_q       <= a10_mask;  // all banks
          wait_cnt  <= wait_width'(t_rp - 2);
          ret_state <= st_init_ref1;
          state     <= st_wait;
        end
        st_init_ref1: begin
          cmd_q     <= cmd_refresh;
          wait_cnt  <= wait_width'(t_rfc - 2);
          ret_state <= st_init_ref2;
          state     <= st_wait;
        end
        st_init_ref2: begin
          cmd_q     <= cmd_refresh;
          wait_cnt  <= wait_width'(t_rfc - 2);
          ret_state <= st_load_mode;
          state     <= st_wait;
        end
        st_load_mode: begin
          cmd_q     <= cmd_load_mode;
          ba_q      <= '0;
          a_q       <= mode_word;
          wait_cnt  <= wait_width'(t_mrd - 2);
          ret_state <= st_idle;
          state     <= st_wait;
          init_done <= 1'b1;
        end
        st_idle: begin
          if (ref_take) begin
            cmd_q     <= cmd_refresh;
            wait_cnt  <= wait_width'(t_rfc - 2);
            ret_state <= st_idle;
            state     <= st_wait;
          end else if (req.stb && !ack_q) begin  // stb still high in ack cycle
            cmd_q     <= cmd_active;
            ba_q      <= bank;
            a_q       <= row_a;
            wait_cnt  <= wait_width'(t_rcd - 2);
            ret_state <= req.we ? st_write : st_read;
            state     <= st_wait;
          end
        end
        st_read: begin
          cmd_q    <= cmd_read;
          ba_q     <= bank;
          a_q      <= col_a;
          wait_cnt <= wait_width'(cas_latency);
          state    <= st_read_wait;
        end
        st_read_wait: begin
          if (wait_cnt == '0) begin
            ack_q <= 1'b1;  // rdata captured on this edge
            state <= st_idle;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        st_write: begin
          cmd_q <= cmd_write;
          ba_q  <= bank;
          a_q   <= col_a;
          dq_oe <= 1'b1;
          state <= st_write_ack;
        end
        st_write_ack: begin
          ack_q     <= 1'b1;
          wait_cnt  <= wait_width'(t_wr_ap - 3);  // counted from the write command
          ret_state <= st_idle;
          state     <= st_wait;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data path
  always_ff @(posedge clk) begin
    if (state == st_read_wait && wait_cnt == '0)
      rdata_q <= dq;
    if (state == st_write)
      dq_out <= req.wdata;
  end

  assign dq = dq_oe ? dq_out : 'z;

  assign rsp.ack   = ack_q;
  assign rsp.rdata = rdata_q;

  assign pins.cke = 1'b1;
  assign pins.cmd = cmd_q;
  assign pins.ba  = ba_q;
  assign pins.a   = a_q;
  assign pins.dqm = '0;

  a_no_ack_in_init: assert property (
    @(posedge clk) disable iff (rst)
    !init_done |-> !rsp.ack
  ) else $error("ack before SDRAM init finished");

  a_ack_or_refresh: assert property (
    @(posedge clk) disable iff (rst)
    !(rsp.ack && pins.cmd == cmd_refresh)
  ) else $error("ack and refresh in the same cycle");

  // bus turnaround relies on dq being released outside the write cycle
  a_dq_drive: assert property (
    @(posedge clk) disable iff (rst)
    dq_oe == (pins.cmd == cmd_write)
  ) else $error("dq drive does not match write command");

endmodule

// File: rtl/memtest.sv
/*
  memory test top: sequencer + SDRAM controller on a single clock.
  sdram_clk is clk itself; no PLL phase shift, board timing must allow that
*/
`timescale 1ns/1ps

module memtest #(
  parameter int unsigned test_last_addr = 1023,
  parameter int          heartbeat_bits = 26
) (
  input  logic        clk,
  input  logic        rst,
  output logic        sdram_clk,
  output logic        sdram_cke,
  output logic        sdram_cs_n,
  output logic        sdram_ras_n,
  output logic        sdram_cas_n,
  output logic        sdram_we_n,
  output logic [1:0]  sdram_ba,
  output logic [12:0] sdram_a,
  output logic [3:0]  sdram_dqm,
  inout  wire  [memtest_pkg::data_width-1:0] sdram_dq,
  output logic [17:0] led_r,
  output logic [8:0]  led_g
);

  import memtest_pkg::*;
  import sdram_pkg::*;

  mem_req_t                  req;
  mem_rsp_t                  rsp;
  sdram_pins_t               pins;
  logic                      test_ended;
  logic                      test_error;
  logic [heartbeat_bits-1:0] heartbeat;

  ramtest #(
    .test_last_addr(test_last_addr)
  ) ramtest_1 (
    .clk       (clk),
    .rst       (rst),
    .rsp       (rsp),
    .req       (req),
    .test_ended(test_ended),
    .test_error(test_error)
  );

  ramctrl ramctrl_1 (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp),
    .pins(pins),
    .dq  (sdram_dq)
  );

  assign sdram_clk = clk;
  assign sdram_cke = pins.cke;
  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = pins.cmd;
  assign sdram_ba  = pins.ba;
  assign sdram_a   = pins.a;
  assign sdram_dqm = pins.dqm;

  // heartbeat, top bit blinks
  always_ff @(posedge clk) begin
    if (rst)
      heartbeat <= '0;
    else
      heartbeat <= heartbeat + 1'b1;
  end

  assign led_r = {17'b0, test_error};
  // g7 ended, g2 heartbeat, g0 reset
  assign led_g = {1'b0, test_ended, 4'b0, heartbeat[heartbeat_bits-1], 1'b0, rst};

endmodule

// File: test/sdram_model.sv
/*
  behavioral SDR SDRAM, burst length 1, CAS latency 2, no timing checks.
  stuck_en forces one read data bit to 1; bad command order raises order_error
*/
`timescale 1ns/1ps

module sdram_model (
  input  logic        clk,
  input  logic        cs_n,
  input  logic        ras_n,
  input  logic        cas_n,
  input  logic        we_n,
  input  logic [1:0]  ba,
  input  logic [12:0] a,
  inout  wire  [31:0] dq,
  input  logic        stuck_en,
  input  logic [4:0]  stuck_bit,
  output logic        order_error
);

  import sdram_pkg::*;

  logic [31:0] mem [int];  // keyed by {ba, row, col}
  logic [3:0]  bank_open = '0;
  logic [12:0] open_row [4];
  logic        mode_set  = 1'b0;
  logic        rd_pend   = 1'b0;
  int          rd_addr   = 0;
  logic        dq_oe     = 1'b0;
  logic [31:0] dq_q;
  logic [31:0] stuck_mask;
  sdram_cmd_t  cmd;

  initial order_error = 1'b0;

  assign cmd        = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
  assign stuck_mask = stuck_en ? (32'd1 << stuck_bit) : 32'd0;
  assign dq         = dq_oe ? dq_q : 'z;

  function automatic int word_addr(input logic [1:0] b, input logic [12:0] col);
    return int'({b, open_row[b], col[9:0]});
  endfunction

  task automatic order_fail(input string what);
    $display("SDRAM model: %s at %0t", what, $time);
    order_error <= 1'b1;
  endtask

  always @(posedge clk) begin
    // data goes out one cycle after the read, valid at the following edge
    dq_oe   <= rd_pend;
    dq_q    <= (mem.exists(rd_addr) ? mem[rd_addr] : 32'd0) | stuck_mask;
    rd_pend <= 1'b0;
    case (cmd)
      cmd_active: begin
        if (!mode_set)
          order_fail("activate before the mode register was loaded");
        if (bank_open[ba])
          order_fail("activate to a bank that is already open");
        bank_open[ba] <= 1'b1;
        open_row[ba]  <= a;
      end
      cmd_read, cmd_write: begin
        if (!bank_open[ba]) begin
          order_fail("read or write to a closed bank");
        end else if (cmd == cmd_write) begin
          mem[word_addr(ba, a)] = dq;
        end else begin
          rd_pend <= 1'b1;
          rd_addr <= word_addr(ba, a);
        end
        if (a[10])
          bank_open[ba] <= 1'b0;  // auto-precharge
      end
      cmd_precharge: begin
        if (a[10])
          bank_open <= '0;
        else
          bank_open[ba] <= 1'b0;
      end
      cmd_refresh, cmd_load_mode: begin
        if (bank_open != '0)
          order_fail("refresh or mode load while a bank is open");
        if (cmd == cmd_load_mode)
          mode_set <= 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: test/tb_memtest.sv
/*
  directed tests of memtest on the behavioral SDRAM over a 64-word range.
  each wait is bounded; the first failing check ends the run
*/
`timescale 1ns/1ps

module tb_memtest;

  import sdram_pkg::*;

  localparam int last_addr  = 63;
  localparam int access_max = 16;  // longest single access, with margin
  localparam int run_limit  = 20000;

  logic        clk = 1'b0;
  logic        rst;
  logic        stuck_en;
  logic [4:0]  stuck_bit;
  integer      seed;
  wire         sdram_clk, sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n;
  wire  [1:0]  sdram_ba;
  wire  [12:0] sdram_a;
  wire  [3:0]  sdram_dqm;
  wire  [31:0] sdram_dq;
  wire  [17:0] led_r;
  wire  [8:0]  led_g;
  wire         order_error;

  sdram_cmd_t  cmd;
  sdram_cmd_t  cmd_log [$];  // first non-NOP commands after reset
  logic [12:0] a_log [$];
  int          cycle;
  int          last_ref;
  int          ref_count;

  memtest #(
    .test_last_addr(last_addr),
    .heartbeat_bits(6)
  ) uut (
    .clk(clk), .rst(rst), .sdram_clk(sdram_clk), .sdram_cke(sdram_cke),
    .sdram_cs_n(sdram_cs_n), .sdram_ras_n(sdram_ras_n), .sdram_cas_n(sdram_cas_n),
    .sdram_we_n(sdram_we_n), .sdram_ba(sdram_ba), .sdram_a(sdram_a),
    .sdram_dqm(sdram_dqm), .sdram_dq(sdram_dq), .led_r(led_r), .led_g(led_g)
  );

  sdram_model sdram (
    .clk(sdram_clk), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n), .cas_n(sdram_cas_n),
    .we_n(sdram_we_n), .ba(sdram_ba), .a(sdram_a), .dq(sdram_dq),
    .stuck_en(stuck_en), .stuck_bit(stuck_bit), .order_error(order_error)
  );

  always #2 clk = ~clk;

  assign cmd = sdram_cmd_t'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // pin monitor, sampled mid-cycle: command log and refresh spacing
  always @(negedge clk) begin
    if (order_error)
      fail_run("the SDRAM model saw an illegal command order");
    check_value("sdram_cke", sdram_cke, 1'b1);
    check_value("sdram_dqm", sdram_dqm, 4'h0);
    check_value("led_g spare bits", led_g & 9'h17a, 9'h0);  // only g7, g2, g0 used
    if (rst) begin
      cmd_log.delete();
      a_log.delete();
      cycle     = 0;
      last_ref  = -1;
      ref_count = 0;
    end else begin
      cycle++;
      if (cmd != cmd_nop && cmd_log.size() < 16) begin
        cmd_log.push_back(cmd);
        a_log.push_back(sdram_a);
      end
      if (cmd == cmd_refresh) begin
        if (last_ref >= 0 && cycle - last_ref > refresh_interval + access_max)
          fail_run($sformatf("refresh gap of %0d cycles is too long", cycle - last_ref));
        last_ref = cycle;
        ref_count++;
      end
    end
  end

  task automatic reset_state_test();
    for (int i = 0; i < 10; i++) begin
      next_cycle();
      check_value("led_r", led_r, 18'h0);
      check_value("led_g[7]", led_g[7], 1'b0);
      check_value("led_g[0]", led_g[0], 1'b1);
      check_value("sdram cmd", cmd, cmd_nop);
    end
    rst = 1'b0;
    next_cycle();
    check_value("led_r", led_r, 18'h0);
    check_value("led_g[7]", led_g[7], 1'b0);
    check_value("led_g[0]", led_g[0], 1'b0);
    check_value("sdram cmd", cmd, cmd_nop);
  endtask

  task automatic wait_toggle(output int n);
    logic prev;
    prev = led_g[2];
    n = 0;
    while (led_g[2] == prev) begin
      next_cycle();
      n++;
      if (n > 64)
        fail_run("the heartbeat LED did not toggle within 64 cycles");
    end
  endtask

  task automatic heartbeat_test();
    int n;
    wait_toggle(n);  // first edge, phase unknown
    wait_toggle(n);
    check_value("heartbeat half period", n, 32);
  endtask

  task automatic init_order_test();
    int n;
    int first_act;
    n = 0;
    while (cmd_log.size() < 5) begin
      next_cycle();
      n++;
      if (n > 400)
        fail_run("SDRAM init did not finish within 400 cycles");
    end
    check_value("cmd_log[0]", cmd_log[0], cmd_precharge);
    check_value("a_log[0][10]", a_log[0][10], 1'b1);
    check_value("cmd_log[1]", cmd_log[1], cmd_refresh);
    check_value("cmd_log[2]", cmd_log[2], cmd_refresh);
    check_value("cmd_log[3]", cmd_log[3], cmd_load_mode);
    // CAS latency 2, sequential, burst length 1
    check_value("a_log[3]", a_log[3], {6'b0, 3'd2, 1'b0, 3'd0});
    first_act = -1;
    foreach (cmd_log[i])
      if (cmd_log[i] == cmd_active && first_act < 0)
        first_act = i;
    check_value("first active after init", first_act >= 4, 1'b1);
  endtask

  task automatic wait_test_end(input logic clean);
    int n;
    n = 0;
    while (!led_g[7]) begin
      next_cycle();
      n++;
      if (clean)
        check_value("led_r[0]", led_r[0], 1'b0);
      if (n > run_limit)
        fail_run($sformatf("test_ended did not rise within %0d cycles", run_limit));
    end
  endtask

  task automatic clean_pass_test();
    wait_test_end(1'b1);
    check_value("led_r", led_r, 18'h0);
    check_value("periodic refresh seen", ref_count > 2, 1'b1);  // beyond the two in init
    for (int i = 0; i <= last_addr; i++)
      check_value($sformatf("sdram.mem[%0d]", i), sdram.mem[i], ~32'(i));
  endtask

  task automatic fault_test();
    rst       = 1'b1;
    stuck_en  = 1'b1;
    stuck_bit = 5'($unsigned($random(seed)) % 25);
    for (int i = 0; i < 10; i++)
      next_cycle();
    rst = 1'b0;
    wait_test_end(1'b0);
    check_value("led_r[0]", led_r[0], 1'b1);
    check_value("led_r", led_r, 18'h1);  // only the error LED
  endtask

  initial begin
    rst       = 1'b1;
    stuck_en  = 1'b0;
    stuck_bit = '0;
    seed      = 32'h3afa9eb8;
    reset_state_test();
    heartbeat_test();
    init_order_test();
    clean_pass_test();
    fault_test();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: build.f
rtl/memtest_pkg.sv
rtl/sdram_pkg.sv
rtl/ramtest.sv
rtl/ramctrl.sv
rtl/memtest.sv
test/sdram_model.sv
test/tb_memtest.sv

// File: Makefile
# Verilator build and run of the memtest testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing -f build.f --top-module tb_memtest -o tb_memtest

run: compile
	./obj_dir/tb_memtest

clean:
	rm -rf obj_dir
